// ==== Bender.yml ====
package:
  name: video_pattern

sources:
  # packages first, then the pixel path stages, then the top
  - hw/videoTimingPkg.sv
  - hw/pixelFormatPkg.sv
  - hw/pixelPosGen.sv
  - hw/testPatternGen.sv
  - hw/pixelStreamOut.sv
  - hw/videoPatternTop.sv
  - target: test
    files:
      - test/videoPatternTb.sv

// ==== hw/pixelFormatPkg.sv ====
/*
 * Pixel colour format, pattern modes and the output stream beat.
 * RGB565 throughout. The bar table follows the usual eight-bar order
 * from white down to black.
 */
`default_nettype none

package pixelFormatPkg;

    typedef struct packed {
        logic [4:0] r;
        logic [5:0] g;
        logic [4:0] b;
    } rgb565T;

    typedef enum logic [1:0] {
        patGradient  = 2'd0,
        patChecker   = 2'd1,
        patColorBars = 2'd2,
        patSolid     = 2'd3
    } patternModeT;

    // full scale and zero for the checker squares
    localparam rgb565T colorWhite = '{r: 5'h1f, g: 6'h3f, b: 5'h1f};
    localparam rgb565T colorBlack = '{r: 5'h00, g: 6'h00, b: 5'h00};

    // bars left to right, selected by hPos bits 5..3
    localparam rgb565T barColors [8] = '{
        '{r: 5'h1f, g: 6'h3f, b: 5'h1f},
        '{r: 5'h1f, g: 6'h3f, b: 5'h00},
        '{r: 5'h00, g: 6'h3f, b: 5'h1f},
        '{r: 5'h00, g: 6'h3f, b: 5'h00},
        '{r: 5'h1f, g: 6'h00, b: 5'h1f},
        '{r: 5'h1f, g: 6'h00, b: 5'h00},
        '{r: 5'h00, g: 6'h00, b: 5'h1f},
        '{r: 5'h00, g: 6'h00, b: 5'h00}
    };

    // output stream beat, colour plus frame flags
    typedef struct packed {
        rgb565T color;
        logic   sof;
        logic   eol;
        logic   eof;
    } pixelBeatT;

endpackage

`default_nettype wire

// ==== hw/pixelPosGen.sv ====
/*
 * Pixel coordinate counter with no blanking.
 * Positions advance one pixel per accepted beat. Frame size, pattern
 * mode and solid colour are captured after reset and again on the
 * transfer of the eof beat, so a frame never changes shape mid-way.
 */
`timescale 1ns/1ps
`default_nettype none

module pixelPosGen
    import videoTimingPkg::*, pixelFormatPkg::*;
#(
    parameter int pHdisplayWidth = 11,
    parameter int pVdisplayWidth = 11
)(
    input  wire logic        iSysClk,
    input  wire logic        arstN,
    input  wire frameSizeT   frameSize,
    input  wire patternModeT patternMode,
    input  wire rgb565T      solidColor,
    input  wire logic        posReady,
    output pixelPosT         posBeat,
    output logic             posValid,
    output patternModeT      frameMode,
    output rgb565T           frameColor
);

    logic [pHdisplayWidth-1:0] hCnt;
    logic [pVdisplayWidth-1:0] vCnt;
    logic [pHdisplayWidth-1:0] hSize;
    logic [pVdisplayWidth-1:0] vSize;
    logic                      lastCol;
    logic                      lastRow;
    logic                      posXfer;
    logic                      loadShadow;

    //------------------------------------------------------------
    // end-of-line and end-of-frame detect
    //------------------------------------------------------------
    assign lastCol = (hCnt == hSize - 1'b1);
    assign lastRow = (vCnt == vSize - 1'b1);
    assign posXfer = posValid && posReady;

    // first edge out of reset, or the eof beat leaving
    assign loadShadow = !posValid || (posXfer && lastCol && lastRow);

    //------------------------------------------------------------
    // frame shadow registers
    //------------------------------------------------------------
    always_ff @(posedge iSysClk or negedge arstN)
    begin
        if (!arstN)
        begin
            hSize      <= '0;
            vSize      <= '0;
            frameMode  <= patGradient;
            frameColor <= '0;
        end
        else if (loadShadow)
        begin
            // upper bits beyond the counter width are dropped
            hSize      <= frameSize.hDisplay[pHdisplayWidth-1:0];
            vSize      <= frameSize.vDisplay[pVdisplayWidth-1:0];
            frameMode  <= patternMode;
            frameColor <= solidColor;
        end
    end

    //------------------------------------------------------------
    // column and row counters
    //------------------------------------------------------------
    always_ff @(posedge iSysClk or negedge arstN)
    begin
        if (!arstN)
        begin
            hCnt     <= '0;
            vCnt     <= '0;
            posValid <= 1'b0;
        end
        else
        begin
            // always offering a beat once out of reset
            posValid <= 1'b1;
            if (posXfer)
            begin
                if (lastCol)
                begin
                    hCnt <= '0;
                    // row wraps only at the end of the last line
                    vCnt <= lastRow ? '0 : vCnt + 1'b1;
                end
                else
                begin
                    hCnt <= hCnt + 1'b1;
                end
            end
        end
    end

    // coordinate beat, zero-extended to the struct widths
    assign posBeat.hPos = hWidthMax'(hCnt);
    assign posBeat.vPos = vWidthMax'(vCnt);
    assign posBeat.sof  = (hCnt == '0) && (vCnt == '0);
    assign posBeat.eol  = lastCol;
    assign posBeat.eof  = lastCol && lastRow;

endmodule

`default_nettype wire

// ==== hw/pixelStreamOut.sv ====
/*
 * Skid-buffer output stage for the pixel stream.
 * patReady comes straight from a register, so downstream ready never
 * reaches the pattern stage through logic. A beat that arrives while
 * the output is stalled waits in the skid entry and leaves first.
 */
`timescale 1ns/1ps
`default_nettype none

module pixelStreamOut
    import pixelFormatPkg::*;
(
    input  wire logic      iSysClk,
    input  wire logic      arstN,
    input  wire pixelBeatT patBeat,
    input  wire logic      patValid,
    input  wire logic      pixReady,
    output logic           patReady,
    output pixelBeatT      pixOut,
    output logic           pixValid
);

    pixelBeatT skidBeat;
    logic      skidValid;
    logic      inXfer;
    logic      mainFree;

    // upstream may send while the skid entry is empty
    assign patReady = !skidValid;
    assign inXfer   = patValid && patReady;
    // main register empty or being emptied this edge
    assign mainFree = !pixValid || pixReady;

    //------------------------------------------------------------
    // valid bits
    //------------------------------------------------------------
    always_ff @(posedge iSysClk or negedge arstN)
    begin
        if (!arstN)
        begin
            pixValid  <= 1'b0;
            skidValid <= 1'b0;
        end
        else if (mainFree)
        begin
            // skid drains first; no input can arrive while it is full
            pixValid  <= skidValid || inXfer;
            skidValid <= 1'b0;
        end
        else if (inXfer)
        begin
            // output stalled, park the new beat
            skidValid <= 1'b1;
        end
    end

    //------------------------------------------------------------
    // payload registers
    //------------------------------------------------------------
    always_ff @(posedge iSysClk)
    begin
        if (mainFree)
        begin
            if (skidValid)
                pixOut <= skidBeat;
            else if (inXfer)
                pixOut <= patBeat;
        end
        else if (inXfer)
        begin
            skidBeat <= patBeat;
        end
    end

endmodule

`default_nettype wire

// ==== hw/testPatternGen.sv ====
/*
 * One-register pipeline stage turning a coordinate into a colour.
 * The mode and solid colour are sampled with each accepted beat, so
 * every pixel is coloured with the settings of its own frame.
 * Flags pass through unchanged.
 */
`timescale 1ns/1ps
`default_nettype none

module testPatternGen
    import videoTimingPkg::*, pixelFormatPkg::*;
(
    input  wire logic        iSysClk,
    input  wire logic        arstN,
    input  wire pixelPosT    posBeat,
    input  wire logic        posValid,
    input  wire patternModeT frameMode,
    input  wire rgb565T      frameColor,
    input  wire logic        patReady,
    output logic             posReady,
    output pixelBeatT        patBeat,
    output logic             patValid
);

    rgb565T     nextColor;
    logic [4:0] gradBlue;
    logic       checkerOdd;
    logic       posXfer;

    //------------------------------------------------------------
    // colour rules
    //------------------------------------------------------------
    // low five bits of hPos plus vPos
    assign gradBlue   = posBeat.hPos[4:0] + posBeat.vPos[4:0];
    // 8x8 squares
    assign checkerOdd = posBeat.hPos[3] ^ posBeat.vPos[3];

    always_comb
    begin
        unique case (frameMode)
            patGradient:
            begin
                nextColor.r = posBeat.hPos[4:0];
                nextColor.g = posBeat.vPos[5:0];
                nextColor.b = gradBlue;
            end
            patChecker:
            begin
                nextColor = checkerOdd ? colorWhite : colorBlack;
            end
            patColorBars:
            begin
                // eight-pixel wide bars, repeating every 64 columns
                nextColor = barColors[posBeat.hPos[5:3]];
            end
            default:
            begin
                // patSolid
                nextColor = frameColor;
            end
        endcase
    end

    //------------------------------------------------------------
    // pipeline register
    //------------------------------------------------------------
    // accept when empty or when the held beat leaves this edge
    assign posReady = !patValid || patReady;
    assign posXfer  = posValid && posReady;

    always_ff @(posedge iSysClk or negedge arstN)
    begin
        if (!arstN)
        begin
            patValid <= 1'b0;
        end
        else if (posReady)
        begin
            patValid <= posValid;
        end
    end

    // payload, loaded only on a transfer
    always_ff @(posedge iSysClk)
    begin
        if (posXfer)
        begin
            patBeat.color <= nextColor;
            patBeat.sof   <= posBeat.sof;
            patBeat.eol   <= posBeat.eol;
            patBeat.eof   <= posBeat.eof;
        end
    end

endmodule

`default_nettype wire

// ==== hw/videoPatternTop.sv ====
/*
 * Test-pattern pixel source, top level.
 * Chains the coordinate counter, the pattern stage and the skid
 * output stage. Frame inputs are sampled only at frame boundaries;
 * output is a valid/ready stream of RGB565 beats with frame flags.
 */
`timescale 1ns/1ps
`default_nettype none

module videoPatternTop
    import videoTimingPkg::*, pixelFormatPkg::*;
#(
    parameter int pHdisplayWidth = 11,
    parameter int pVdisplayWidth = 11
)(
    input  wire logic        iSysClk,
    input  wire logic        arstN,
    input  wire frameSizeT   frameSize,
    input  wire patternModeT patternMode,
    input  wire rgb565T      solidColor,
    input  wire logic        pixReady,
    output pixelBeatT        pixOut,
    output logic             pixValid
);

    //------------------------------------------------------------
    // stage links
    //------------------------------------------------------------
    pixelPosT    posBeat;
    logic        posValid;
    logic        posReady;
    patternModeT frameMode;
    rgb565T      frameColor;
    pixelBeatT   patBeat;
    logic        patValid;
    logic        patReady;

    // coordinates plus the frame-latched settings
    pixelPosGen #(
        .pHdisplayWidth (pHdisplayWidth),
        .pVdisplayWidth (pVdisplayWidth)
    ) uPosGen (
        .iSysClk     (iSysClk),
        .arstN       (arstN),
        .frameSize   (frameSize),
        .patternMode (patternMode),
        .solidColor  (solidColor),
        .posReady    (posReady),
        .posBeat     (posBeat),
        .posValid    (posValid),
        .frameMode   (frameMode),
        .frameColor  (frameColor)
    );

    // coordinate to colour
    testPatternGen uPatGen (
        .iSysClk    (iSysClk),
        .arstN      (arstN),
        .posBeat    (posBeat),
        .posValid   (posValid),
        .frameMode  (frameMode),
        .frameColor (frameColor),
        .patReady   (patReady),
        .posReady   (posReady),
        .patBeat    (patBeat),
        .patValid   (patValid)
    );

    // registered back-pressure toward the pattern stage
    pixelStreamOut uStreamOut (
        .iSysClk  (iSysClk),
        .arstN    (arstN),
        .patBeat  (patBeat),
        .patValid (patValid),
        .pixReady (pixReady),
        .patReady (patReady),
        .pixOut   (pixOut),
        .pixValid (pixValid)
    );

endmodule

`default_nettype wire

// ==== hw/videoTimingPkg.sv ====
/*
 * Coordinate widths and the structs that carry pixel positions and
 * the requested frame size through the pattern source.
 * Imported by the position counter, the pattern stage and the top.
 */
`default_nettype none

package videoTimingPkg;

    // widest counters the structs can hold
    // module width parameters must stay at or below these
    localparam int hWidthMax = 11;
    localparam int vWidthMax = 11;

    // one coordinate beat, position counter to pattern stage
    typedef struct packed {
        logic [hWidthMax-1:0] hPos;
        logic [vWidthMax-1:0] vPos;
        logic                 sof;
        logic                 eol;
        logic                 eof;
    } pixelPosT;

    // requested frame size in pixels and lines, each at least 1
    typedef struct packed {
        logic [hWidthMax-1:0] hDisplay;
        logic [vWidthMax-1:0] vDisplay;
    } frameSizeT;

endpackage

`default_nettype wire

// ==== sources.f ====
hw/videoTimingPkg.sv
hw/pixelFormatPkg.sv
hw/pixelPosGen.sv
hw/testPatternGen.sv
hw/pixelStreamOut.sv
hw/videoPatternTop.sv
test/videoPatternTb.sv

// ==== test/videoPatternTb.sv ====
/*
 * Testbench for the test-pattern pixel source.
 * Table rows set frame size, pattern mode, solid colour, downstream
 * stall rate and frame count. Every accepted pixel is compared with
 * a reference walk over the coordinates. A watchdog bounds the run.
 */
`timescale 1ns/1ps
`default_nettype none

module videoPatternTb
    import videoTimingPkg::*, pixelFormatPkg::*;
();

    localparam int maxRows     = 8;
    localparam int resetCycles = 16;

    logic        iSysClk = 1'b0;
    logic        arstN;
    frameSizeT   frameSize;
    patternModeT patternMode;
    rgb565T      solidColor;
    logic        pixReady;
    pixelBeatT   pixOut;
    logic        pixValid;

    // stimulus table with one entry per row
    string       testName [maxRows];
    int          hDisp    [maxRows];
    int          vDisp    [maxRows];
    patternModeT modeTab  [maxRows];
    rgb565T      colorTab [maxRows];
    int          stallPct [maxRows];
    int          frameTab [maxRows];
    int          rowCount = 0;

    int mismatchCount = 0;
    int otherCount    = 0;
    int pixelsSeen    = 0;
    int pixelsTotal   = 0;
    int watchdogCycles = 0;

    videoPatternTop #(
        .pHdisplayWidth (11),
        .pVdisplayWidth (11)
    ) i_dut (
        .iSysClk     (iSysClk),
        .arstN       (arstN),
        .frameSize   (frameSize),
        .patternMode (patternMode),
        .solidColor  (solidColor),
        .pixReady    (pixReady),
        .pixOut      (pixOut),
        .pixValid    (pixValid)
    );

    // 100 ns period
    always #50 iSysClk = ~iSysClk;

    //------------------------------------------------------------
    // table and reference helpers
    //------------------------------------------------------------
    task automatic addRow(input string name, input int h, input int v,
                          input patternModeT mode, input rgb565T color,
                          input int stall, input int frames);
        testName[rowCount] = name;
        hDisp[rowCount]    = h;
        vDisp[rowCount]    = v;
        modeTab[rowCount]  = mode;
        colorTab[rowCount] = color;
        stallPct[rowCount] = stall;
        frameTab[rowCount] = frames;
        rowCount++;
    endtask

    // frame inputs for the DUT to pick up at its next frame boundary
    task automatic applyRow(input int r);
        frameSize.hDisplay = hDisp[r][10:0];
        frameSize.vDisplay = vDisp[r][10:0];
        patternMode        = modeTab[r];
        solidColor         = colorTab[r];
    endtask

    // expected beat from the colour and flag rules
    function automatic pixelBeatT expectBeat(input int r, input int h, input int v);
        pixelBeatT   beat;
        logic [10:0] hb;
        logic [10:0] vb;
        logic [10:0] sum;
        logic [2:0]  bar;
        hb  = h[10:0];
        vb  = v[10:0];
        sum = hb + vb;
        bar = hb[5:3];
        case (modeTab[r])
            patGradient:  beat.color = {hb[4:0], vb[5:0], sum[4:0]};
            patChecker:   beat.color = (hb[3] != vb[3]) ? 16'hffff : 16'h0000;
            // white yellow cyan green magenta red blue black
            patColorBars: beat.color = {{5{~bar[1]}}, {6{~bar[2]}}, {5{~bar[0]}}};
            default:      beat.color = colorTab[r];
        endcase
        beat.sof = (h == 0) && (v == 0);
        beat.eol = (h == hDisp[r] - 1);
        beat.eof = beat.eol && (v == vDisp[r] - 1);
        return beat;
    endfunction

    task automatic printCounts();
        $display("errors: %0d mismatches, %0d other failures", mismatchCount, otherCount);
    endtask

    //------------------------------------------------------------
    // main sequence
    //------------------------------------------------------------
    initial
    begin
        int        r;
        int        f;
        int        h;
        int        v;
        pixelBeatT expBeat;

        arstN       = 1'b0;
        frameSize   = '0;
        patternMode = patGradient;
        solidColor  = '0;
        pixReady    = 1'b0;
        void'($urandom(41));

        // 1x1 stays last since its frames are shorter than the pipeline
        addRow("gradient16x8",   16, 8, patGradient,  16'h0000,  0, 2);
        addRow("checker64x4",    64, 4, patChecker,   16'h0000, 50, 1);
        addRow("colorBars64x4",  64, 4, patColorBars, 16'h0000, 50, 2);
        addRow("sizeModeChange", 40, 3, patChecker,   16'h0000, 20, 2);
        addRow("heavyStall16x4", 16, 4, patGradient,  16'h0000, 90, 3);
        addRow("solid1x1",        1, 1, patSolid,     16'ha5c3, 30, 4);

        for (int i = 0; i < rowCount; i++)
            pixelsTotal += hDisp[i] * vDisp[i] * frameTab[i];
        watchdogCycles = pixelsTotal * 4 + resetCycles;

        applyRow(0);

        // output must stay idle while in reset
        repeat (resetCycles)
        begin
            @(negedge iSysClk);
            assert (pixValid === 1'b0)
            else
            begin
                otherCount++;
                $display("pixValid went high while reset was asserted");
            end
        end
        arstN = 1'b1;

        r = 0;
        f = 0;
        h = 0;
        v = 0;
        while (r < rowCount)
        begin
            @(negedge iSysClk);
            pixReady = ($urandom % 100) >= stallPct[r];
            // beat offered now is taken on the coming rising edge
            if (pixValid && pixReady)
            begin
                expBeat = expectBeat(r, h, v);
                assert (pixOut === expBeat)
                else
                begin
                    mismatchCount++;
                    $display("mismatch %s pixel (%0d,%0d) frame %0d: expected %h actual %h",
                             testName[r], h, v, f, expBeat, pixOut);
                end
                // next row goes in during the last frame of this one
                if (h == 0 && v == 0 && f == frameTab[r] - 1 && r + 1 < rowCount)
                    applyRow(r + 1);
                pixelsSeen++;
                if (h == hDisp[r] - 1)
                begin
                    h = 0;
                    if (v == vDisp[r] - 1)
                    begin
                        v = 0;
                        f++;
                        if (f == frameTab[r])
                        begin
                            f = 0;
                            r++;
                        end
                    end
                    else
                    begin
                        v++;
                    end
                end
                else
                begin
                    h++;
                end
            end
        end

        @(negedge iSysClk);
        pixReady = 1'b0;
        printCounts();
        if (mismatchCount + otherCount == 0)
            $display("TEST PASSED");
        else
            $display("TEST FAILED");
        $finish;
    end

    //------------------------------------------------------------
    // watchdog
    //------------------------------------------------------------
    initial
    begin
        wait (watchdogCycles > 0);
        repeat (watchdogCycles) @(posedge iSysClk);
        otherCount++;
        $display("stream stalled: %0d of %0d pixels arrived before %0d cycles ran out",
                 pixelsSeen, pixelsTotal, watchdogCycles);
        printCounts();
        $display("TEST FAILED");
        $finish;
    end

endmodule

`default_nettype wire
